//--- include/pwm_params.svh
// Register map and sizing for the PWM generator
// Offsets are byte offsets from PWM_BASE_ADDRESS, one 32-bit word per register
// Only the low 16 bits of the period and compare words are kept

`ifndef PWM_PARAMS_SVH
`define PWM_PARAMS_SVH

// Bus address of register 0
`define PWM_BASE_ADDRESS 32'h43c0_0000

// Register offsets
`define PWM_REG_CTRL   32'h0000_0000
`define PWM_REG_PERIOD 32'h0000_0004
// Channel c compare register at PWM_REG_CMP0 + 4*c
`define PWM_REG_CMP0   32'h0000_0008

// Compare channels, each driving a complementary pair
`define PWM_CHANNELS 6

// Output state while stopped, until the host writes one
`define PWM_STOPPED_RESET 12'h000

`endif

//--- hw/pwm_pkg.sv
// Shared types of the PWM generator
// Output vector holds channel c at bit 2c (high side) and 2c+1 (low side)

`default_nettype none

`include "pwm_params.svh"

package pwm_pkg;

    // Bus side
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // Counter value, period and compare thresholds
    typedef logic [15:0] count_t;

    // Prescaler exponent, tick every 2^setting clocks
    typedef logic [2:0] tb_setting_t;

    // Complementary output pairs
    typedef logic [2*`PWM_CHANNELS-1:0] out_state_t;

    // Control unit command FSM
    typedef enum logic [1:0] {
        idle      = 2'd0,
        act       = 2'd1,
        soft_stop = 2'd2
    } cu_state_t;

endpackage

`default_nettype wire

//--- hw/pwm_ctrl_if.sv
// Settings and commands from the control unit to timebase and counter
// sync is a single-cycle pulse; running comes back from the counter

`default_nettype none

`include "pwm_params.svh"

interface pwm_ctrl_if;
    import pwm_pkg::*;

    tb_setting_t setting;
    logic        tb_enable;
    logic        ext_enable;
    logic        run;
    logic        stop_request;
    logic        sync;
    count_t      period;
    count_t      compare [`PWM_CHANNELS];
    out_state_t  stopped_state;
    logic        running;

    modport ctrl (
        output setting, tb_enable, ext_enable, run, stop_request, sync,
        output period, compare, stopped_state,
        input  running
    );

    modport core (
        input  setting, tb_enable, ext_enable, run, stop_request, sync,
        input  period, compare, stopped_state,
        output running
    );

endinterface

`default_nettype wire

//--- hw/pwm_control_unit.sv
// Register bus slave and command FSM of the PWM generator
// A write is taken only while ready is high; ready then drops for 2 cycles,
// or until the counter has stopped when the write requests a soft stop
// Timebase fields written while the counter runs are dropped

`default_nettype none

`include "pwm_params.svh"

module pwm_control_unit (
    input  wire                  clock,
    input  wire                  reset,
    input  wire pwm_pkg::bus_addr_t address,
    input  wire pwm_pkg::bus_data_t write_data,
    input  wire                  write_strobe,
    output pwm_pkg::bus_data_t   read_data,
    output logic                 ready,
    pwm_ctrl_if.ctrl             ctrl
);
    import pwm_pkg::*;

    cu_state_t state;
    bus_addr_t latched_offset;
    bus_data_t latched_data;
    bus_data_t ctrl_word;
    bus_addr_t read_offset;
    logic      act_done;

    assign read_offset = address - `PWM_BASE_ADDRESS;

    // Readback of the addressed register, unmapped offsets read zero
    always_comb begin
        read_data = '0;
        if (read_offset == `PWM_REG_CTRL) begin
            read_data = ctrl_word;
        end else if (read_offset == `PWM_REG_PERIOD) begin
            read_data = bus_data_t'(ctrl.period);
        end
        for (int c = 0; c < `PWM_CHANNELS; c++) begin
            if (read_offset == `PWM_REG_CMP0 + 32'(4 * c)) begin
                read_data = bus_data_t'(ctrl.compare[c]);
            end
        end
    end

    // Capture the write while idle
    always_ff @(posedge clock) begin
        if (state == idle && write_strobe) begin
            latched_offset <= address - `PWM_BASE_ADDRESS;
            latched_data <= write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            ready <= 1'b1;
            act_done <= 1'b0;
            ctrl_word <= '0;
            ctrl.setting <= '0;
            ctrl.tb_enable <= 1'b0;
            ctrl.ext_enable <= 1'b0;
            ctrl.run <= 1'b0;
            ctrl.stop_request <= 1'b0;
            ctrl.sync <= 1'b0;
            ctrl.period <= '0;
            for (int c = 0; c < `PWM_CHANNELS; c++) begin
                ctrl.compare[c] <= '0;
            end
            ctrl.stopped_state <= `PWM_STOPPED_RESET;
        end else begin
            // sync only lasts the cycle after it is applied
            ctrl.sync <= 1'b0;

            case (state)
                idle: begin
                    act_done <= 1'b0;
                    if (write_strobe) begin
                        ready <= 1'b0;
                        state <= act;
                    end
                end

                act: begin
                    if (!act_done) begin
                        act_done <= 1'b1;
                        if (latched_offset == `PWM_REG_CTRL) begin
                            if (latched_data[7]) begin
                                // Sync-only write, the rest of the word is ignored
                                ctrl.sync <= 1'b1;
                            end else begin
                                ctrl_word <= latched_data;
                                if (!ctrl.running) begin
                                    ctrl.setting <= latched_data[2:0];
                                    ctrl.tb_enable <= latched_data[3];
                                    ctrl.ext_enable <= latched_data[4];
                                end
                                ctrl.run <= latched_data[5];
                                ctrl.stopped_state <= latched_data[19:8];
                                if (latched_data[6]) begin
                                    ctrl.stop_request <= 1'b1;
                                    state <= soft_stop;
                                end
                            end
                        end else if (latched_offset == `PWM_REG_PERIOD) begin
                            ctrl.period <= latched_data[15:0];
                        end
                        for (int c = 0; c < `PWM_CHANNELS; c++) begin
                            if (latched_offset == `PWM_REG_CMP0 + 32'(4 * c)) begin
                                ctrl.compare[c] <= latched_data[15:0];
                            end
                        end
                    end else begin
                        // Second act cycle closes the write
                        state <= idle;
                        ready <= 1'b1;
                    end
                end

                soft_stop: begin
                    // Counter drops running on its final wrap
                    if (!ctrl.running) begin
                        ctrl.stop_request <= 1'b0;
                        ctrl.run <= 1'b0;
                        ready <= 1'b1;
                        state <= idle;
                    end
                end

                default: begin
                    state <= idle;
                    ready <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/pwm_timebase.sv
// Count tick source: 2^setting clock divider or external tick input
// ext_tick is asynchronous and passes a two-stage synchronizer,
// so it must stay high and low for at least two clocks each

`default_nettype none

module pwm_timebase (
    input  wire      clock,
    input  wire      reset,
    input  wire      ext_tick,
    pwm_ctrl_if.core ctrl,
    output logic     tick
);

    logic [7:0] prescaler;
    logic [7:0] mask;
    logic [1:0] ext_sync;
    logic       ext_prev;
    logic       ext_rise;
    logic       divider_tick;

    // Low setting bits of the prescaler all ones once per 2^setting clocks
    assign mask = (8'd1 << ctrl.setting) - 8'd1;
    assign divider_tick = (prescaler & mask) == mask;

    assign ext_rise = ext_sync[1] && !ext_prev;

    always_ff @(posedge clock) begin
        if (!reset) begin
            prescaler <= '0;
        end else if (!ctrl.tb_enable) begin
            prescaler <= '0;
        end else begin
            prescaler <= prescaler + 8'd1;
        end
    end

    // External tick synchronizer and edge detect
    always_ff @(posedge clock) begin
        if (!reset) begin
            ext_sync <= '0;
            ext_prev <= 1'b0;
        end else begin
            ext_sync <= {ext_sync[0], ext_tick};
            ext_prev <= ext_sync[1];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            tick <= 1'b0;
        end else if (!ctrl.tb_enable) begin
            tick <= 1'b0;
        end else if (ctrl.ext_enable) begin
            tick <= ext_rise;
        end else begin
            tick <= divider_tick;
        end
    end

endmodule

`default_nettype wire

//--- hw/pwm_counter.sv
// Shared period counter and six compare channels with complementary outputs
// Count runs 0 .. period-1; a period of 0 or 1 keeps it at 0
// Outputs are registered and lag the count by one cycle
// A soft stop takes effect on the wrap to 0

`default_nettype none

`include "pwm_params.svh"

module pwm_counter (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  tick,
    pwm_ctrl_if.core             ctrl,
    output pwm_pkg::out_state_t  pwm_out
);
    import pwm_pkg::*;

    count_t                    count;
    logic [16:0]               count_inc;
    logic                      wrap;
    logic [`PWM_CHANNELS-1:0]  high_side;
    out_state_t                active_out;

    // Extra bit so the compare holds for period 0 and 16'hffff
    assign count_inc = {1'b0, count} + 17'd1;
    assign wrap = count_inc >= {1'b0, ctrl.period};

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            ctrl.running <= 1'b0;
        end else if (!ctrl.running) begin
            count <= '0;
            // No restart while a soft stop is still being closed
            if (ctrl.run && !ctrl.stop_request) begin
                ctrl.running <= 1'b1;
            end
        end else if (!ctrl.run) begin
            // Hard stop
            ctrl.running <= 1'b0;
            count <= '0;
        end else if (ctrl.sync) begin
            count <= '0;
        end else if (tick) begin
            if (wrap) begin
                count <= '0;
                if (ctrl.stop_request) begin
                    ctrl.running <= 1'b0;
                end
            end else begin
                count <= count_inc[15:0];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < `PWM_CHANNELS; c++) begin
            high_side[c] = count < ctrl.compare[c];
            active_out[2 * c] = high_side[c];
            active_out[2 * c + 1] = !high_side[c];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_out <= `PWM_STOPPED_RESET;
        end else if (ctrl.running) begin
            pwm_out <= active_out;
        end else begin
            pwm_out <= ctrl.stopped_state;
        end
    end

endmodule

`default_nettype wire

//--- hw/pwm_top.sv
// PWM generator top level with a simple register bus and twelve outputs
// Host must raise write_strobe for one cycle, only while ready is high
// ext_tick is used only with external enable set in the control register

`default_nettype none

module pwm_top (
    input  wire                     clock,
    input  wire                     reset,
    input  wire pwm_pkg::bus_addr_t address,
    input  wire pwm_pkg::bus_data_t write_data,
    input  wire                     write_strobe,
    output pwm_pkg::bus_data_t      read_data,
    output logic                    ready,
    input  wire                     ext_tick,
    output pwm_pkg::out_state_t     pwm_out
);

    wire tick;

    pwm_ctrl_if ctrl_bus ();

    pwm_control_unit u_control_unit (
        .clock        (clock),
        .reset        (reset),
        .address      (address),
        .write_data   (write_data),
        .write_strobe (write_strobe),
        .read_data    (read_data),
        .ready        (ready),
        .ctrl         (ctrl_bus.ctrl)
    );

    pwm_timebase u_timebase (
        .clock    (clock),
        .reset    (reset),
        .ext_tick (ext_tick),
        .ctrl     (ctrl_bus.core),
        .tick     (tick)
    );

    // Counter also reports running back to the control unit
    pwm_counter u_counter (
        .clock   (clock),
        .reset   (reset),
        .tick    (tick),
        .ctrl    (ctrl_bus.core),
        .pwm_out (pwm_out)
    );

endmodule

`default_nettype wire

//--- verification/pwm_clock_gen.sv
// Testbench clock and active-low reset
// Reset is released on a falling edge after reset_cycles rising edges

`default_nettype none

module pwm_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/pwm_tb.sv
// Testbench of the PWM generator, inputs driven on the falling clock edge
// Runs with period 10 and prescaler exponent 2, so one PWM period is 40 clocks

`default_nettype none

`include "pwm_params.svh"

module pwm_tb;
    import pwm_pkg::*;

    localparam int test_period = 10;
    localparam int test_setting = 2;
    localparam int window = test_period << test_setting;
    // Worst case in clocks, reset and then one term per test
    // Writes take 3 cycles and reads 1, an external pulse 7
    localparam int test_cycles = 10 + 7 * 4 + 4 + (8 * 3 + 8 * window)
        + (2 * 3 + 4 * window) + (3 * window + 5) + (2 * 3 + 5 * 7 + 3);
    localparam int cycle_limit = 2 * test_cycles;

    logic       clock;
    logic       reset;
    bus_addr_t  address;
    bus_data_t  write_data;
    logic       write_strobe;
    bus_data_t  read_data;
    logic       ready;
    logic       ext_tick;
    out_state_t pwm_out;

    logic [31:0] lfsr = 32'h626f_5924;
    int          compare_values [`PWM_CHANNELS];
    int          errors = 0;
    int          pair_errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          errors_at_start;
    logic        pair_check = 1'b0;
    logic [5:0]  high_sides;
    logic [5:0]  low_sides;

    pwm_clock_gen #(.period(40), .reset_cycles(8)) u_clock_gen (.clock(clock), .reset(reset));

    pwm_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .address      (address),
        .write_data   (write_data),
        .write_strobe (write_strobe),
        .read_data    (read_data),
        .ready        (ready),
        .ext_tick     (ext_tick),
        .pwm_out      (pwm_out)
    );

    assign high_sides = {pwm_out[10], pwm_out[8], pwm_out[6], pwm_out[4], pwm_out[2], pwm_out[0]};
    assign low_sides = {pwm_out[11], pwm_out[9], pwm_out[7], pwm_out[5], pwm_out[3], pwm_out[1]};

    // Low side is the complement of the high side while the outputs are active
    pair_complement: assert property (@(posedge clock) pair_check |-> low_sides == ~high_sides)
        else begin
            pair_errors++;
            $display("Fail t=%0t pwm_out low sides got %b expected %b",
                     $time, $sampled(low_sides), ~$sampled(high_sides));
        end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return value;
    endfunction

    function automatic bus_data_t control_word(input int setting, input logic tb_en,
            input logic ext_en, input logic run, input logic stop, input logic [11:0] stopped);
        return {12'd0, stopped, 1'b0, stop, run, ext_en, tb_en, 3'(setting)};
    endfunction

    // Output vector for a given count, from the compare rule
    function automatic out_state_t expected_out(input int count);
        out_state_t value;
        for (int c = 0; c < `PWM_CHANNELS; c++) begin
            value[2 * c] = count < compare_values[c];
            value[2 * c + 1] = !(count < compare_values[c]);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_true(input logic condition, input string what);
        checks++;
        assert (condition) else begin
            errors++;
            $display("Error t=%0t %s", $time, what);
        end
    endtask

    task automatic bus_write(input logic [31:0] offset, input bus_data_t data,
            output int low_cycles);
        address = `PWM_BASE_ADDRESS + offset;
        write_data = data;
        write_strobe = 1'b1;
        @(negedge clock);
        write_strobe = 1'b0;
        low_cycles = 0;
        while (!ready) begin
            low_cycles++;
            @(negedge clock);
        end
    endtask

    task automatic read_reg(input logic [31:0] offset, output bus_data_t data);
        address = `PWM_BASE_ADDRESS + offset;
        @(negedge clock);
        data = read_data;
    endtask

    task automatic ext_pulse();
        ext_tick = 1'b1;
        repeat (3) @(negedge clock);
        ext_tick = 1'b0;
        repeat (4) @(negedge clock);
    endtask

    task automatic start_test();
        tests++;
        errors_at_start = errors + pair_errors;
    endtask

    task automatic end_test(input string title);
        if (errors + pair_errors == errors_at_start) begin
            $display("Test %0d %s: ok", tests, title);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed", tests, title);
        end
    endtask

    initial begin
        int         low;
        int         high_count;
        int         width;
        bus_data_t  value;
        bus_data_t  word;
        logic [11:0] stopped;

        address = `PWM_BASE_ADDRESS;
        write_data = '0;
        write_strobe = 1'b0;
        ext_tick = 1'b0;
        @(posedge reset);
        @(negedge clock);

        start_test();
        word = random_bits(16);
        bus_write(`PWM_REG_PERIOD, word, low);
        check_value("ready low cycles", low, 2);
        read_reg(`PWM_REG_PERIOD, value);
        check_value("read_data period", value, word);
        for (int c = 0; c < `PWM_CHANNELS; c++) begin
            word = random_bits(16);
            bus_write(`PWM_REG_CMP0 + 4 * c, word, low);
            check_value("ready low cycles", low, 2);
            read_reg(`PWM_REG_CMP0 + 4 * c, value);
            check_value($sformatf("read_data compare %0d", c), value, word);
        end
        end_test("register readback");

        start_test();
        stopped = random_bits(12);
        word = control_word(test_setting, 1'b0, 1'b0, 1'b0, 1'b0, stopped);
        bus_write(`PWM_REG_CTRL, word, low);
        read_reg(`PWM_REG_CTRL, value);
        check_value("read_data control", value, word);
        check_value("pwm_out", pwm_out, stopped);
        end_test("stopped state");

        start_test();
        for (int c = 0; c < `PWM_CHANNELS; c++) begin
            compare_values[c] = random_bits(4);
            bus_write(`PWM_REG_CMP0 + 4 * c, compare_values[c], low);
        end
        bus_write(`PWM_REG_PERIOD, test_period, low);
        stopped = random_bits(12);
        bus_write(`PWM_REG_CTRL, control_word(test_setting, 1, 0, 1, 0, stopped), low);
        // Let the prescaler and count reach their steady cycle
        repeat (2 * window) @(negedge clock);
        pair_check = 1'b1;
        for (int c = 0; c < `PWM_CHANNELS; c++) begin
            high_count = 0;
            repeat (window) begin
                @(negedge clock);
                high_count += pwm_out[2 * c];
            end
            check_value($sformatf("pwm_out[%0d] high cycles", 2 * c), high_count,
                ((compare_values[c] < test_period) ? compare_values[c] : test_period)
                << test_setting);
        end
        pair_check = 1'b0;
        end_test("duty cycle");

        start_test();
        compare_values[0] = 1;
        bus_write(`PWM_REG_CMP0, 1, low);
        bus_write(`PWM_REG_CTRL, control_word(0, 1, 0, 1, 0, stopped), low);
        repeat (window) @(negedge clock);
        // Channel 0 is high only for count 0, one tick spacing wide
        while (pwm_out[0]) @(negedge clock);
        while (!pwm_out[0]) @(negedge clock);
        width = 0;
        while (pwm_out[0]) begin
            width++;
            @(negedge clock);
        end
        check_value("pwm_out[0] high cycles", width, 1 << test_setting);
        end_test("settings locked while running");

        start_test();
        stopped = random_bits(12);
        bus_write(`PWM_REG_CTRL, control_word(test_setting, 1, 0, 1, 1, stopped), low);
        check_true(low <= window + 4, "soft stop held ready low longer than one period");
        check_value("pwm_out", pwm_out, stopped);
        repeat (2 * window) begin
            @(negedge clock);
            check_value("pwm_out", pwm_out, stopped);
        end
        end_test("soft stop");

        start_test();
        bus_write(`PWM_REG_CTRL, control_word(0, 1, 1, 1, 0, stopped), low);
        repeat (2) @(negedge clock);
        check_value("pwm_out", pwm_out, expected_out(0));
        for (int k = 1; k <= 4; k++) begin
            ext_pulse();
            check_value("pwm_out", pwm_out, expected_out(k));
        end
        bus_write(`PWM_REG_CTRL, 32'h0000_0080, low);
        @(negedge clock);
        check_value("pwm_out", pwm_out, expected_out(0));
        ext_pulse();
        check_value("pwm_out", pwm_out, expected_out(1));
        end_test("sync and external tick");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors + pair_errors);
        if (errors + pair_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hw/pwm_pkg.sv
hw/pwm_ctrl_if.sv
hw/pwm_control_unit.sv
hw/pwm_timebase.sv
hw/pwm_counter.sv
hw/pwm_top.sv
verification/pwm_clock_gen.sv
verification/pwm_tb.sv

//--- Bender.yml
package:
  name: pwm

sources:
  - include_dirs:
      - include
    files:
      - hw/pwm_pkg.sv
      - hw/pwm_ctrl_if.sv
      - hw/pwm_control_unit.sv
      - hw/pwm_timebase.sv
      - hw/pwm_counter.sv
      - hw/pwm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/pwm_clock_gen.sv
      - verification/pwm_tb.sv
